// File: Bender.yml
package:
  name: mont_multiplier

sources:
  - verilog/montPkg.sv
  - verilog/montOperandRegs.sv
  - verilog/montAccumulator.sv
  - verilog/montBitCounter.sv
  - verilog/montControl.sv
  - verilog/montMultiplier.sv
  - target: test
    files:
      - tests/tbMontgomery.sv

// File: files.f
verilog/montPkg.sv
verilog/montOperandRegs.sv
verilog/montAccumulator.sv
verilog/montBitCounter.sv
verilog/montControl.sv
verilog/montMultiplier.sv
tests/tbMontgomery.sv

// File: tests/montCases.txt
# columns: name, A, B, M, expected result A*B*2^-64 mod M, all hex
# subtract cases: mMinusOne nearTop negPair m2Sub
zeroA        0000000000000000 123456789abcdef0 ffffffffffffffff 0000000000000000
oneA         0000000000000001 0123456789abcdef ffffffffffffffff 0123456789abcdef
oneB         fedcba9876543210 0000000000000001 ffffffffffffffff fedcba9876543210
pow32        0000000100000000 0000000100000000 ffffffffffffffff 0000000000000001
mMinusOne    fffffffffffffffe fffffffffffffffe ffffffffffffffff 0000000000000001
topHalf      8000000000000000 fffffffffffffffd ffffffffffffffff fffffffffffffffe
nearTop      fffffffffffffff0 fffffffffffffff0 ffffffffffffffff 00000000000000e1
highWord     ffffffff00000000 ffffffff00000000 ffffffffffffffff fffffffe00000001
negPair      fffffffffffffffe fffffffffffffffd ffffffffffffffff 0000000000000002
rInverse     0000000000000001 0000000000000001 7fffffffffffffff 4000000000000000
twoByOne     0000000000000002 0000000000000001 7fffffffffffffff 0000000000000001
m2MinusOne   7ffffffffffffffe 7ffffffffffffffe 7fffffffffffffff 4000000000000000
m2Sub        7ffffffffffffffe 7ffffffffffffffd 7fffffffffffffff 0000000000000001
smallOdd     0000000000000003 0000000000000005 7fffffffffffffff 4000000000000007
invThree     0000000000000001 0000000000000001 fffffffffffffffd aaaaaaaaaaaaaaa9
minusInv     fffffffffffffffc 0000000000000001 fffffffffffffffd 5555555555555554
threeByNeg   0000000000000003 fffffffffffffffc fffffffffffffffd fffffffffffffffc
smallMod     0000000080000000 0000000000000004 00000000ffffffff 0000000000000002
smallModNeg  00000000fffffffe 0000000000010000 00000000ffffffff 00000000fffeffff

// File: tests/tbMontgomery.sv
`timescale 1ns/1ps

module tbMontgomery;

    localparam int Width     = 64;
    localparam int Latency   = 2 * Width + 3;  // start edge through the edge raising done
    localparam int CaseSlack = 16;
    localparam int MaxCases  = 64;
    localparam int BusyCycle = 40;             // lands inside the AddB/AddM loop

    logic             clk;
    logic             resetn;
    logic             start;
    logic [Width-1:0] a;
    logic [Width-1:0] b;
    logic [Width-1:0] m;
    logic [Width-1:0] result;
    logic             done;

    string            caseName [MaxCases];
    logic [Width-1:0] caseA    [MaxCases];
    logic [Width-1:0] caseB    [MaxCases];
    logic [Width-1:0] caseM    [MaxCases];
    logic [Width-1:0] caseRes  [MaxCases];
    int               numCases   = 0;
    int               cycleCount = 0;
    int               cycleLimit = 0;  // zero until the cases are loaded

    montMultiplier #(.Width(Width)) DUT (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .a      (a),
        .b      (b),
        .m      (m),
        .result (result),
        .done   (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stopOnError(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkResult(input string name, input logic [Width-1:0] expected,
                               input logic [Width-1:0] actual);
        if (actual !== expected)
        begin
            stopOnError($sformatf("[FAIL] %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic checkCycles(input string name, input int expected, input int actual);
        if (actual != expected)
        begin
            stopOnError($sformatf("[FAIL] %s: expected %0d cycles, actual %0d cycles",
                                  name, expected, actual));
        end
    endtask

    task automatic checkDone(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            stopOnError($sformatf("[FAIL] %s: expected done %b, actual %b",
                                  name, expected, actual));
        end
    endtask

    // one case per line and # lines are skipped
    task automatic loadCases();
        int               fd;
        int               fields;
        string            line;
        string            tag;
        logic [Width-1:0] va;
        logic [Width-1:0] vb;
        logic [Width-1:0] vm;
        logic [Width-1:0] vr;
        fd = $fopen("tests/montCases.txt", "r");
        if (fd == 0)
        begin
            stopOnError("could not open the case file tests/montCases.txt");
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line.substr(0, 0) != "#")
                begin
                    fields = $sscanf(line, "%s %h %h %h %h", tag, va, vb, vm, vr);
                    if (fields == 5 && numCases < MaxCases)
                    begin
                        caseName[numCases] = tag;
                        caseA[numCases]    = va;
                        caseB[numCases]    = vb;
                        caseM[numCases]    = vm;
                        caseRes[numCases]  = vr;
                        numCases++;
                    end
                end
            end
            $fclose(fd);
            if (numCases == 0)
            begin
                stopOnError("the case file tests/montCases.txt holds no cases");
            end
        end
    endtask

    task automatic runCase(input int idx);
        int    cycles;
        int    gap;
        string name;
        name  = caseName[idx];
        a     = caseA[idx];
        b     = caseB[idx];
        m     = caseM[idx];
        start = 1'b1;
        @(posedge clk);
        #1;
        cycles = 1;  // edge that sampled start
        while (done !== 1'b1)
        begin
            if (idx % 2 == 1 && cycles == BusyCycle)
            begin
                start = 1'b1;  // stray strobe while the DUT is busy
                a     = ~caseA[idx];
                b     = ~caseB[idx];
            end
            else
            begin
                start = 1'b0;
            end
            @(posedge clk);
            #1;
            cycles++;
        end
        checkCycles({name, " latency"}, Latency, cycles);
        checkResult(name, caseRes[idx], result);
        @(posedge clk);
        #1;
        checkDone({name, " done pulse"}, 1'b0, done);
        gap = $urandom % 8 + 2;
        repeat (gap)
        begin
            checkResult({name, " hold"}, caseRes[idx], result);
            checkDone({name, " idle"}, 1'b0, done);
            @(posedge clk);
            #1;
        end
        checkResult({name, " hold"}, caseRes[idx], result);
    endtask

    always @(posedge clk)
    begin
        cycleCount = cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit)
        begin
            stopOnError($sformatf("simulation timed out after %0d clock cycles", cycleCount));
        end
    end

    initial
    begin
        void'($urandom(32'h8913));  // fixes the idle gaps
        resetn = 1'b0;
        start  = 1'b0;
        a      = '0;
        b      = '0;
        m      = '0;
        loadCases();
        cycleLimit = (numCases + 2) * (Latency + CaseSlack);
        repeat (4)
        begin
            @(posedge clk);
            #1;
            checkDone("reset", 1'b0, done);
        end
        resetn = 1'b1;
        repeat (3)
        begin
            @(posedge clk);
            #1;
            checkDone("idle after reset", 1'b0, done);
        end
        for (int i = 0; i < numCases; i++)
        begin
            runCase(i);
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: verilog/montAccumulator.sv
`timescale 1ns/1ps

module montAccumulator #(
    parameter int Width = 512
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  montPkg::montCtrlT     ctrl,
    input  logic [Width-1:0]      bOut,
    input  logic [Width-1:0]      mOut,
    output logic                  accOdd,
    output logic [Width-1:0]      result
);

    // two guard bits, the running value stays below 4M
    localparam int AccW = Width + 2;

    logic [AccW-1:0] acc;
    logic [AccW-1:0] addend;
    logic [AccW-1:0] sum;
    logic [AccW:0]   diff;   // msb is the borrow
    logic [AccW-1:0] twoM;

    always_comb
    begin
        case (ctrl.addSel)
            montPkg::AddB: addend = {2'b00, bOut};
            montPkg::AddM: addend = {2'b00, mOut};
            default:       addend = '0;
        endcase
    end

    assign sum  = acc + addend;
    assign diff = {1'b0, acc} - {3'b000, mOut};
    assign twoM = {1'b0, mOut, 1'b0};

    always_ff @(posedge clk)
    begin
        if (ctrl.loadOps)
        begin
            acc <= '0;
        end
        else if (ctrl.reduce)
        begin
            if (!diff[AccW])
            begin
                acc <= diff[AccW-1:0];  // keep only when no borrow
            end
        end
        else if (ctrl.halve)
        begin
            acc <= {1'b0, sum[AccW-1:1]};
        end
        else
        begin
            acc <= sum;  // AddZero holds the value
        end
    end

    // parity of the running sum, decides whether M gets added
    assign accOdd = acc[0];
    assign result = acc[Width-1:0];

    // one subtract is enough only if the loop kept acc below 2M
    belowTwoM: assert property (
        @(posedge clk) disable iff (!resetn)
        ctrl.reduce |-> (acc < twoM)
    );

    // FSM must have made the sum even before halving
    evenBeforeHalve: assert property (
        @(posedge clk) disable iff (!resetn)
        ctrl.halve |-> !sum[0]
    );

endmodule

// File: verilog/montBitCounter.sv
`timescale 1ns/1ps

module montBitCounter #(
    parameter int Width = 512
) (
    input  logic               clk,
    input  logic               resetn,
    input  montPkg::montCtrlT  ctrl,
    output logic               lastBit
);

    localparam int CntW = $clog2(Width);

    logic [CntW-1:0] count;

    always_ff @(posedge clk)
    begin
        if (!resetn || ctrl.loadOps)
        begin
            count <= '0;
        end
        else if (ctrl.countEn)
        begin
            count <= count + 1'b1;
        end
    end

    assign lastBit = (count == CntW'(Width - 1));

    // no further step once the final bit was counted, until the next load
    noCountPastLast: assert property (
        @(posedge clk) disable iff (!resetn)
        (ctrl.countEn && lastBit) |=> (!ctrl.countEn until ctrl.loadOps)
    );

endmodule

// File: verilog/montControl.sv
`timescale 1ns/1ps

module montControl (
    input  logic               clk,
    input  logic               resetn,
    input  logic               start,
    input  montPkg::montStatT  stat,
    output montPkg::montCtrlT  ctrl,
    output logic               done
);

    montPkg::montStateT state;
    montPkg::montStateT nextState;

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            state <= montPkg::StIdle;
            done  <= 1'b0;
        end
        else
        begin
            state <= nextState;
            done  <= (nextState == montPkg::StFinish);
        end
    end

    always_comb
    begin
        nextState = state;
        case (state)
            montPkg::StIdle:
            begin
                if (start)
                begin
                    nextState = montPkg::StLoad;
                end
            end
            montPkg::StLoad:   nextState = montPkg::StAddB;
            montPkg::StAddB:   nextState = montPkg::StAddM;
            montPkg::StAddM:
            begin
                // lastBit means this AddM finishes bit Width-1
                if (stat.lastBit)
                begin
                    nextState = montPkg::StReduce;
                end
                else
                begin
                    nextState = montPkg::StAddB;
                end
            end
            montPkg::StReduce: nextState = montPkg::StFinish;
            montPkg::StFinish: nextState = montPkg::StIdle;
            default:           nextState = montPkg::StIdle;
        endcase
    end

    always_comb
    begin
        ctrl = '0;  // AddZero, nothing enabled
        case (state)
            montPkg::StLoad:
            begin
                ctrl.loadOps = 1'b1;
            end
            montPkg::StAddB:
            begin
                ctrl.addSel = stat.aBit ? montPkg::AddB : montPkg::AddZero;
            end
            montPkg::StAddM:
            begin
                ctrl.addSel  = stat.accOdd ? montPkg::AddM : montPkg::AddZero;
                ctrl.halve   = 1'b1;
                ctrl.shiftA  = 1'b1;
                ctrl.countEn = 1'b1;
            end
            montPkg::StReduce:
            begin
                ctrl.reduce = 1'b1;
            end
            default:
            begin
                ctrl = '0;
            end
        endcase
    end

endmodule

// File: verilog/montMultiplier.sv
`timescale 1ns/1ps

module montMultiplier #(
    parameter int Width = 512
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic              start,
    input  logic [Width-1:0]  a,
    input  logic [Width-1:0]  b,
    input  logic [Width-1:0]  m,
    output logic [Width-1:0]  result,
    output logic              done
);

    montPkg::montCtrlT ctrl;
    montPkg::montStatT stat;

    logic [Width-1:0] bOut;
    logic [Width-1:0] mOut;
    logic             aBit;
    logic             accOdd;
    logic             lastBit;

    assign stat = {aBit, accOdd, lastBit};  // field order of montStatT

    montControl uControl (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .stat   (stat),
        .ctrl   (ctrl),
        .done   (done)
    );

    montOperandRegs #(.Width(Width)) uOperands (
        .clk    (clk),
        .resetn (resetn),
        .ctrl   (ctrl),
        .a      (a),
        .b      (b),
        .m      (m),
        .bOut   (bOut),
        .mOut   (mOut),
        .aBit   (aBit)
    );

    montAccumulator #(.Width(Width)) uAccumulator (
        .clk    (clk),
        .resetn (resetn),
        .ctrl   (ctrl),
        .bOut   (bOut),
        .mOut   (mOut),
        .accOdd (accOdd),
        .result (result)
    );

    montBitCounter #(.Width(Width)) uBitCounter (
        .clk     (clk),
        .resetn  (resetn),
        .ctrl    (ctrl),
        .lastBit (lastBit)
    );

endmodule

// File: verilog/montOperandRegs.sv
`timescale 1ns/1ps

module montOperandRegs #(
    parameter int Width = 512
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  montPkg::montCtrlT     ctrl,
    input  logic [Width-1:0]      a,
    input  logic [Width-1:0]      b,
    input  logic [Width-1:0]      m,
    output logic [Width-1:0]      bOut,
    output logic [Width-1:0]      mOut,
    output logic                  aBit
);

    logic [Width-1:0] aShift;  // multiplier, consumed lsb first
    logic [Width-1:0] bReg;
    logic [Width-1:0] mReg;

    always_ff @(posedge clk)
    begin
        if (ctrl.loadOps)
        begin
            aShift <= a;
            bReg   <= b;
            mReg   <= m;
        end
        else if (ctrl.shiftA)
        begin
            aShift <= {1'b0, aShift[Width-1:1]};
        end
    end

    assign aBit = aShift[0];
    assign bOut = bReg;
    assign mOut = mReg;

    // montgomery reduction needs an odd modulus
    modulusOdd: assert property (
        @(posedge clk) disable iff (!resetn)
        ctrl.loadOps |-> m[0]
    );

endmodule

// File: verilog/montPkg.sv
package montPkg;

    // addend picked by the accumulator each cycle
    typedef enum logic [1:0] {
        AddZero,
        AddB,
        AddM
    } addSelT;

    // control word from the FSM to the data path
    typedef struct packed {
        logic   loadOps;  // capture operands, clear accumulator
        logic   shiftA;
        addSelT addSel;
        logic   halve;
        logic   reduce;   // final conditional subtract
        logic   countEn;
    } montCtrlT;

    typedef struct packed {
        logic aBit;
        logic accOdd;
        logic lastBit;
    } montStatT;

    // state labels carry a prefix, AddB and AddM are taken by addSelT
    typedef enum logic [2:0] {
        StIdle,
        StLoad,
        StAddB,
        StAddM,
        StReduce,
        StFinish
    } montStateT;

endpackage
